// ==== rtl/lock_pkg.sv ====
`default_nettype none

package lock_pkg;

	////////////////////
	// datapath widths
	////////////////////

	localparam int W_ERR   = 16;	// adc error sample, signed
	localparam int W_OUT   = 16;	// dac / dds output word, signed
	localparam int W_GAIN  = 16;	// kp, ki, kd
	localparam int W_SUM   = 64;	// pid sum, wide enough for the integrator
	localparam int W_MLT   = 10;	// output multiplier, signed
	localparam int W_SHIFT = 6;	// output right shift amount
	localparam int W_ADDR  = 4;	// host register address

	// full scale output codes, also the reset bounds
	localparam logic signed [W_OUT-1:0] OUT_MAX = {1'b0, {(W_OUT-1){1'b1}}};
	localparam logic signed [W_OUT-1:0] OUT_MIN = {1'b1, {(W_OUT-1){1'b0}}};

	////////////////////
	// host register map
	////////////////////

	typedef enum logic [W_ADDR-1:0] {
		ADDR_KP       = 0,	// proportional gain
		ADDR_KI       = 1,	// integral gain
		ADDR_KD       = 2,	// derivative gain
		ADDR_OUT_MAX  = 3,	// upper clamp
		ADDR_OUT_MIN  = 4,	// lower clamp
		ADDR_OUT_INIT = 5,	// output while unlocked
		ADDR_MULT     = 6,
		ADDR_SHIFT    = 7,
		ADDR_LOCK_EN  = 8	// bit 0 only
	} cfg_addr_t;

endpackage

`default_nettype wire

// ==== rtl/lock_cfg_if.sv ====
`default_nettype none

interface lock_cfg_if;
	import lock_pkg::*;

	// filter gains
	logic signed [W_GAIN-1:0]  kp;
	logic signed [W_GAIN-1:0]  ki;
	logic signed [W_GAIN-1:0]  kd;

	// output shaping
	logic signed [W_OUT-1:0]   output_max;
	logic signed [W_OUT-1:0]   output_min;
	logic signed [W_OUT-1:0]   output_init;	// held on the dac while unlocked
	logic signed [W_MLT-1:0]   multiplier;
	logic        [W_SHIFT-1:0] right_shift;

	logic                      lock_en;	// shared by filter and preprocessor

	// register block owns every field
	modport regs (
		output kp, ki, kd,
		output output_max, output_min, output_init,
		output multiplier, right_shift,
		output lock_en
	);

	modport pid (input kp, ki, kd, lock_en);

	modport opp (
		input output_max, output_min, output_init,
		input multiplier, right_shift,
		input lock_en
	);

endinterface

`default_nettype wire

// ==== rtl/cfg_regs.sv ====
`default_nettype none

module cfg_regs (
	input  logic                        clk_in,
	input  logic                        reset_in,
	input  logic                        cfg_write,	// one cycle write strobe
	input  logic [lock_pkg::W_ADDR-1:0] cfg_addr,
	input  logic [15:0]                 cfg_data,
	lock_cfg_if.regs                    cfg
);
	import lock_pkg::*;

	////////////////////
	// register storage
	////////////////////

	logic signed [W_GAIN-1:0]  kp_r;
	logic signed [W_GAIN-1:0]  ki_r;
	logic signed [W_GAIN-1:0]  kd_r;
	logic signed [W_OUT-1:0]   max_r;
	logic signed [W_OUT-1:0]   min_r;
	logic signed [W_OUT-1:0]   init_r;
	logic signed [W_MLT-1:0]   mult_r;	// unity after reset
	logic        [W_SHIFT-1:0] shift_r;
	logic                      lock_en_r;

	// host write, new value visible the cycle after the strobe
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			kp_r      <= '0;
			ki_r      <= '0;
			kd_r      <= '0;
			max_r     <= OUT_MAX;	// full scale until the host narrows it
			min_r     <= OUT_MIN;
			init_r    <= '0;
			mult_r    <= W_MLT'(1);
			shift_r   <= '0;
			lock_en_r <= 1'b0;	// start unlocked
		end else if (cfg_write) begin
			// data word truncated to each field width
			case (cfg_addr_t'(cfg_addr))
				ADDR_KP:       kp_r      <= cfg_data[W_GAIN-1:0];
				ADDR_KI:       ki_r      <= cfg_data[W_GAIN-1:0];
				ADDR_KD:       kd_r      <= cfg_data[W_GAIN-1:0];
				ADDR_OUT_MAX:  max_r     <= cfg_data[W_OUT-1:0];
				ADDR_OUT_MIN:  min_r     <= cfg_data[W_OUT-1:0];
				ADDR_OUT_INIT: init_r    <= cfg_data[W_OUT-1:0];
				ADDR_MULT:     mult_r    <= cfg_data[W_MLT-1:0];	// low bits, signed
				ADDR_SHIFT:    shift_r   <= cfg_data[W_SHIFT-1:0];
				ADDR_LOCK_EN:  lock_en_r <= cfg_data[0];
				default: begin
					// unmapped address, write dropped
				end
			endcase
		end
	end

	////////////////////
	// drive the bus
	////////////////////

	assign cfg.kp          = kp_r;
	assign cfg.ki          = ki_r;
	assign cfg.kd          = kd_r;
	assign cfg.output_max  = max_r;
	assign cfg.output_min  = min_r;
	assign cfg.output_init = init_r;
	assign cfg.multiplier  = mult_r;
	assign cfg.right_shift = shift_r;
	assign cfg.lock_en     = lock_en_r;

endmodule

`default_nettype wire

// ==== rtl/pid_filter.sv ====
`default_nettype none

module pid_filter (
	input  logic                              clk_in,
	input  logic                              reset_in,
	input  logic signed [lock_pkg::W_ERR-1:0] err_data,	// adc error sample
	input  logic                              err_valid,	// one cycle strobe
	lock_cfg_if.pid                           cfg,
	output logic signed [lock_pkg::W_SUM-1:0] pid_sum,
	output logic                              pid_valid
);
	import lock_pkg::*;

	localparam int W_P = W_GAIN + W_ERR;		// kp * e
	localparam int W_D = W_GAIN + W_ERR + 1;	// difference carries one extra bit

	////////////////////
	// internal state
	////////////////////

	logic signed [W_ERR-1:0] err_prev;	// last accepted error, for the d term
	logic signed [W_SUM-1:0] i_acc;	// running integrator total
	logic signed [W_P-1:0]   p_term;
	logic signed [W_D-1:0]   d_term;
	logic                    stage1_valid;	// products ready

	////////////////////
	// stage one
	////////////////////

	// products, only the sample strobe loads them
	always_ff @(posedge clk_in) begin
		if (err_valid) begin
			p_term <= cfg.kp * err_data;
			d_term <= cfg.kd * (err_data - err_prev);	// evaluated at W_D bits
		end
	end

	// integrator and error history
	// both held at zero while unlocked so relock starts clean
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			i_acc    <= '0;
			err_prev <= '0;
		end else if (!cfg.lock_en) begin
			i_acc    <= '0;
			err_prev <= '0;
		end else if (err_valid) begin
			i_acc    <= i_acc + cfg.ki * err_data;	// new total feeds this sample
			err_prev <= err_data;
		end
	end

	////////////////////
	// stage two
	////////////////////

	// p + i + d, all sign extended to W_SUM
	always_ff @(posedge clk_in) begin
		if (stage1_valid) begin
			pid_sum <= p_term + i_acc + d_term;
		end
	end

	// strobe follows the data two edges behind err_valid
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			stage1_valid <= 1'b0;
			pid_valid    <= 1'b0;
		end else begin
			stage1_valid <= err_valid;
			pid_valid    <= stage1_valid;
		end
	end

	////////////////////
	// checks
	////////////////////

	// back to back samples would hand the preprocessor a stretched strobe
	a_pid_valid_pulse: assert property (
		@(posedge clk_in) disable iff (reset_in)
		pid_valid |=> !pid_valid
	) else $error("pid_valid high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== rtl/output_preprocessor.sv ====
`default_nettype none

module output_preprocessor #(
	parameter int COMP_LATENCY = 1	// cycles spent in compute
) (
	input  logic                              clk_in,
	input  logic                              reset_in,
	input  logic signed [lock_pkg::W_SUM-1:0] pid_sum,
	input  logic                              pid_valid,
	lock_cfg_if.opp                           cfg,
	output logic signed [lock_pkg::W_OUT-1:0] data_out,	// to dac / dds
	output logic                              data_valid_out
);
	import lock_pkg::*;

	localparam int W_PROD = W_SUM + W_MLT;	// sum * multiplier
	localparam int W_ACC  = W_PROD + 1;	// room for the add of the previous word
	localparam int W_CNT  = (COMP_LATENCY > 1) ? $clog2(COMP_LATENCY) : 1;
	localparam logic [W_CNT-1:0] CNT_LAST = W_CNT'(COMP_LATENCY - 1);

	// fsm encoding
	localparam logic [1:0] ST_IDLE      = 2'd0;	// wait for a pid sum
	localparam logic [1:0] ST_COMPUTE   = 2'd1;	// let the datapath settle
	localparam logic [1:0] ST_SEND      = 2'd2;	// strobe the output
	localparam logic [1:0] ST_WRITEBACK = 2'd3;	// keep the sent word

	////////////////////
	// internal state
	////////////////////

	logic [1:0]              cur_state;
	logic [1:0]              next_state;
	logic [W_CNT-1:0]        counter;	// cycles inside compute
	logic                    pending;	// sum latched, leave idle next edge
	logic                    accept;
	logic signed [W_SUM-1:0] sum_hold;
	logic signed [W_OUT-1:0] data_out_prev;	// word last sent

	logic signed [W_PROD-1:0] stage_mult;
	logic signed [W_ACC-1:0]  stage_shift;
	logic signed [W_ACC-1:0]  stage_acc;
	logic signed [W_ACC-1:0]  stage_gate;
	logic signed [W_ACC-1:0]  stage_hi;
	logic signed [W_ACC-1:0]  stage_lo;

	// strobes outside idle are dropped
	assign accept = (cur_state == ST_IDLE) && !pending && pid_valid;

	////////////////////
	// datapath
	////////////////////

	assign stage_mult  = sum_hold * cfg.multiplier;	// scale
	assign stage_shift = stage_mult >>> cfg.right_shift;	// divide, keeps sign
	assign stage_acc   = stage_shift + data_out_prev;	// step from last word
	assign stage_gate  = cfg.lock_en ? stage_acc : cfg.output_init;
	assign stage_hi    = (stage_gate > cfg.output_max) ? cfg.output_max : stage_gate;
	assign stage_lo    = (stage_hi < cfg.output_min) ? cfg.output_min : stage_hi;

	assign data_out       = stage_lo[W_OUT-1:0];	// in range after the clamp
	assign data_valid_out = (cur_state == ST_SEND);

	// input latch
	always_ff @(posedge clk_in) begin
		if (accept) begin
			sum_hold <= pid_sum;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			pending <= 1'b0;
		end else begin
			pending <= accept;	// single cycle, fsm moves on it
		end
	end

	// previous output, the accumulator of the servo
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_out_prev <= cfg.output_init;
		end else if (cur_state == ST_WRITEBACK) begin
			data_out_prev <= data_out;	// still the word sent last cycle
		end
	end

	////////////////////
	// fsm
	////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			cur_state <= ST_IDLE;
		end else begin
			cur_state <= next_state;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			counter <= '0;
		end else if (next_state != cur_state) begin
			counter <= '0;	// restart on every transition
		end else if (cur_state == ST_COMPUTE) begin
			counter <= counter + 1'b1;
		end
	end

	always_comb begin
		next_state = cur_state;
		case (cur_state)
			ST_IDLE: begin
				if (pending) next_state = ST_COMPUTE;
			end
			ST_COMPUTE: begin
				if (counter == CNT_LAST) next_state = ST_SEND;
			end
			ST_SEND:      next_state = ST_WRITEBACK;	// one strobe only
			ST_WRITEBACK: next_state = ST_IDLE;
			default:      next_state = ST_IDLE;
		endcase
	end

	////////////////////
	// checks
	////////////////////

	// clamp holds against the live register bounds
	a_out_in_bounds: assert property (
		@(posedge clk_in) disable iff (reset_in)
		(data_valid_out && (cfg.output_min <= cfg.output_max)) |->
			((data_out <= cfg.output_max) && (data_out >= cfg.output_min))
	) else $error("data_out %0d outside bounds", data_out);

	a_valid_pulse: assert property (
		@(posedge clk_in) disable iff (reset_in)
		data_valid_out |=> !data_valid_out
	) else $error("data_valid_out longer than one cycle");

endmodule

`default_nettype wire

// ==== rtl/lock_channel.sv ====
`default_nettype none

module lock_channel #(
	parameter int COMP_LATENCY = 1	// preprocessor compute cycles
) (
	input  logic                              clk_in,
	input  logic                              reset_in,

	// host register port
	input  logic                              cfg_write,
	input  logic [lock_pkg::W_ADDR-1:0]       cfg_addr,
	input  logic [15:0]                       cfg_data,

	// adc side
	input  logic signed [lock_pkg::W_ERR-1:0] err_data,
	input  logic                              err_valid,

	// dac side, no back-pressure
	output logic signed [lock_pkg::W_OUT-1:0] data_out,
	output logic                              data_valid_out
);
	import lock_pkg::*;

	////////////////////
	// internal wiring
	////////////////////

	logic signed [W_SUM-1:0] pid_sum;	// filter to preprocessor
	logic                    pid_valid;

	lock_cfg_if cfg_bus ();	// register values to both blocks

	cfg_regs cfg_regs_i (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.cfg_write (cfg_write),
		.cfg_addr  (cfg_addr),
		.cfg_data  (cfg_data),
		.cfg       (cfg_bus.regs)
	);

	// two cycles sample to sum
	pid_filter pid_filter_i (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.err_data  (err_data),
		.err_valid (err_valid),
		.cfg       (cfg_bus.pid),
		.pid_sum   (pid_sum),
		.pid_valid (pid_valid)
	);

	// 2 + COMP_LATENCY cycles sum to dac strobe
	output_preprocessor #(
		.COMP_LATENCY (COMP_LATENCY)
	) output_preprocessor_i (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.pid_sum        (pid_sum),
		.pid_valid      (pid_valid),
		.cfg            (cfg_bus.opp),
		.data_out       (data_out),
		.data_valid_out (data_valid_out)
	);

endmodule

`default_nettype wire

// ==== bench/lock_channel_tb.sv ====
`default_nettype none

module lock_channel_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import lock_pkg::*;

	localparam int LAT = 6;	// err_valid to data_valid_out with COMP_LATENCY 2

	logic               clk_in = 1'b0;
	logic               reset_in;
	logic               cfg_write;
	logic [W_ADDR-1:0]  cfg_addr;
	logic [15:0]        cfg_data;
	logic signed [15:0] err_data;
	logic               err_valid;
	logic signed [15:0] data_out;
	logic               data_valid_out;
	logic               sent_ok;	// marks samples that must reach the dac

	integer seed = 67;
	int     errors = 0;
	int     checks = 0;
	int     strobes = 0;
	int     accepted = 0;

	////////////////////
	// model state
	////////////////////

	logic signed [15:0] m_kp, m_ki, m_kd;
	logic signed [15:0] m_max, m_min, m_init;
	logic signed [9:0]  m_mult;
	logic [5:0]         m_shift;
	logic               m_lock;
	logic signed [63:0] m_iacc;
	logic signed [15:0] m_eprev;
	logic signed [15:0] m_prev_out;	// last word the dac got
	logic signed [15:0] exp_q[$];

	lock_channel #(.COMP_LATENCY(2)) dut_i (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.cfg_write      (cfg_write),
		.cfg_addr       (cfg_addr),
		.cfg_data       (cfg_data),
		.err_data       (err_data),
		.err_valid      (err_valid),
		.data_out       (data_out),
		.data_valid_out (data_valid_out)
	);

	always #2 clk_in = ~clk_in;	// 4 ns period

	////////////////////
	// checks
	////////////////////

	a_latency: assert property (
		@(posedge clk_in) disable iff (reset_in)
		sent_ok |-> ##LAT data_valid_out
	) else begin
		errors++;
		$display("[FAIL] %0t data_valid_out missing %0d cycles after err_valid", $time, LAT);
	end

	a_one_cycle: assert property (
		@(posedge clk_in) disable iff (reset_in)
		data_valid_out |=> !data_valid_out
	) else begin
		errors++;
		$display("[FAIL] %0t data_valid_out held longer than one cycle", $time);
	end

	// compare each strobe against the predicted word
	always @(posedge clk_in) begin
		if (!reset_in && data_valid_out) begin
			strobes++;
			a_expected: assert (exp_q.size() != 0) else begin
				errors++;
				$display("[FAIL] %0t data_valid_out with no sample pending", $time);
			end
			if (exp_q.size() != 0) begin
				checks++;
				a_data: assert (data_out === exp_q[0]) else begin
					errors++;
					$display("[FAIL] %0t data_out %0d, expected %0d", $time, data_out, exp_q[0]);
				end
				void'(exp_q.pop_front());
			end
		end
	end

	////////////////////
	// stimulus tasks
	////////////////////

	task automatic write_reg(input cfg_addr_t addr, input logic [15:0] data);
		@(posedge clk_in);
		cfg_write <= 1'b1;
		cfg_addr  <= addr;
		cfg_data  <= data;
		@(posedge clk_in);
		cfg_write <= 1'b0;
		case (addr)	// mirror into the model
			ADDR_KP:       m_kp = data;
			ADDR_KI:       m_ki = data;
			ADDR_KD:       m_kd = data;
			ADDR_OUT_MAX:  m_max = data;
			ADDR_OUT_MIN:  m_min = data;
			ADDR_OUT_INIT: m_init = data;
			ADDR_MULT:     m_mult = data[9:0];
			ADDR_SHIFT:    m_shift = data[5:0];
			ADDR_LOCK_EN:  m_lock = data[0];
			default:       ;
		endcase
		if (!m_lock) begin
			m_iacc = '0;	// filter history held clear while unlocked
			m_eprev = '0;
		end
	endtask

	// pid terms followed by the five output steps
	task automatic predict(input logic signed [15:0] e, input bit keep);
		logic signed [63:0] sum;
		logic signed [79:0] res;
		if (m_lock) begin
			m_iacc = m_iacc + m_ki * e;
			sum = m_kp * e + m_iacc + m_kd * (e - m_eprev);
			m_eprev = e;
		end else begin
			sum = '0;
		end
		if (keep) begin
			res = ($signed(sum) * m_mult) >>> m_shift;
			res = m_lock ? res + m_prev_out : m_init;
			if (res > m_max) res = m_max;
			if (res < m_min) res = m_min;
			exp_q.push_back(res[15:0]);
			m_prev_out = res[15:0];
			accepted++;
		end
	endtask

	task automatic drive_sample(input logic signed [15:0] e, input bit keep);
		@(posedge clk_in);
		err_data  <= e;
		err_valid <= 1'b1;
		sent_ok   <= keep;
		predict(e, keep);
		@(posedge clk_in);
		err_valid <= 1'b0;
		sent_ok   <= 1'b0;
	endtask

	task automatic wait_output();
		int n;
		n = 0;
		while (!data_valid_out && n < 20) begin
			@(posedge clk_in);
			n++;
		end
		if (!data_valid_out) begin
			errors++;
			$display("timeout: no data_valid_out after a sample was sent");
		end
	endtask

	task automatic run_samples(input int count, input int span, input int offset);
		logic signed [15:0] e;
		for (int k = 0; k < count; k++) begin
			e = offset + ($random(seed) % span);
			drive_sample(e, 1'b1);
			wait_output();
		end
	endtask

	////////////////////
	// sequence
	////////////////////

	initial begin
		reset_in  <= 1'b1;
		cfg_write <= 1'b0;
		cfg_addr  <= '0;
		cfg_data  <= '0;
		err_data  <= '0;
		err_valid <= 1'b0;
		sent_ok   <= 1'b0;
		m_kp = 0;
		m_ki = 0;
		m_kd = 0;
		m_max = OUT_MAX;
		m_min = OUT_MIN;
		m_init = 0;
		m_mult = 1;
		m_shift = 0;
		m_lock = 0;
		m_iacc = 0;
		m_eprev = 0;
		m_prev_out = 0;
		repeat (5) @(posedge clk_in);
		reset_in <= 1'b0;

		// unlocked dac sits at the init word
		write_reg(ADDR_OUT_INIT, 16'd123);
		run_samples(3, 300, 0);

		// steps pile up with kp alone
		write_reg(ADDR_KP, 16'd3);
		write_reg(ADDR_LOCK_EN, 16'd1);
		run_samples(5, 300, 0);

		// output scaling with a positive then a negative multiplier
		write_reg(ADDR_MULT, 16'd3);
		write_reg(ADDR_SHIFT, 16'd2);
		run_samples(5, 200, 0);
		write_reg(ADDR_MULT, 16'hfffb);	// -5
		write_reg(ADDR_SHIFT, 16'd3);
		run_samples(3, 200, 0);

		// full pid and a relock from the init word
		write_reg(ADDR_MULT, 16'd1);
		write_reg(ADDR_SHIFT, 16'd0);
		write_reg(ADDR_KP, 16'd2);
		write_reg(ADDR_KI, 16'd1);
		write_reg(ADDR_KD, 16'd4);
		run_samples(6, 100, 0);
		write_reg(ADDR_LOCK_EN, 16'd0);
		run_samples(1, 100, 0);
		write_reg(ADDR_LOCK_EN, 16'd1);
		run_samples(4, 100, 0);

		// tight bounds with runs into both rails
		write_reg(ADDR_KI, 16'd0);
		write_reg(ADDR_KD, 16'd0);
		write_reg(ADDR_KP, 16'd50);
		write_reg(ADDR_OUT_MAX, 16'd200);
		write_reg(ADDR_OUT_MIN, 16'hff38);	// -200
		run_samples(4, 10, 100);
		run_samples(6, 10, -100);

		// second strobe lands while busy and still feeds the integrator
		write_reg(ADDR_KI, 16'd1);
		for (int k = 0; k < 2; k++) begin
			drive_sample(16'sd4, 1'b1);
			drive_sample(16'sd2, 1'b0);
			wait_output();
		end
		run_samples(2, 20, 0);

		repeat (10) @(posedge clk_in);
		a_count: assert (strobes == accepted) else begin
			errors++;
			$display("[FAIL] %0t %0d output strobes for %0d samples", $time, strobes, accepted);
		end

		$display("checks %0d, strobes %0d, errors %0d", checks, strobes, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== lock_channel.f ====
rtl/lock_pkg.sv
rtl/lock_cfg_if.sv
rtl/cfg_regs.sv
rtl/pid_filter.sv
rtl/output_preprocessor.sv
rtl/lock_channel.sv
bench/lock_channel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lock channel testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module lock_channel_tb \
	-f lock_channel.f \
	-o lock_channel_sim

./obj_dir/lock_channel_sim > sim.log 2>&1
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
else
	echo "simulation did not report a pass"
	exit 1
fi
